// ==== source/RvTypes.sv ====
`default_nettype none

package RvTypes;

    typedef logic [31:0] Data;           // Register or ALU value
    typedef logic [31:0] InstAddr;       // Program counter
    typedef logic [31:0] Inst;           // Instruction word
    typedef logic [4:0]  RegAddr;        // Register index

    // ADD must stay at zero, it is the bubble operation
    typedef enum logic [3:0] {
        AluOp_ADD,
        AluOp_SUB,
        AluOp_SLL,
        AluOp_SLT,
        AluOp_SLTU,
        AluOp_XOR,
        AluOp_SRL,
        AluOp_SRA,
        AluOp_OR,
        AluOp_AND
    } AluOp;

    typedef enum logic [1:0] {
        DataAccess_BYTE,                 // Same encoding as funct3[1:0]
        DataAccess_HALF,
        DataAccess_WORD
    } DataAccess;

    typedef enum logic [1:0] {
        OperandASel_REG,
        OperandASel_PC,
        OperandASel_ZERO
    } OperandASel;

    typedef enum logic {
        OperandBSel_REG,
        OperandBSel_IMM
    } OperandBSel;

    typedef enum logic {
        RegWrDataSel_ALU,
        RegWrDataSel_MEM
    } RegWrDataSel;

    localparam logic [6:0] opcodeOp    = 7'b0110011;
    localparam logic [6:0] opcodeOpImm = 7'b0010011;
    localparam logic [6:0] opcodeLui   = 7'b0110111;
    localparam logic [6:0] opcodeAuipc = 7'b0010111;
    localparam logic [6:0] opcodeLoad  = 7'b0000011;
    localparam logic [6:0] opcodeStore = 7'b0100011;

    typedef struct packed {
        RegAddr      regWrAddr;
        logic        regWrEnable;
        RegWrDataSel regWrDataSel;
        logic        memWrEnable;
        logic        memRdEnable;
        DataAccess   memAccess;
        logic        memUnsigned;
        OperandASel  operandASel;
        OperandBSel  operandBSel;
        AluOp        aluControl;
    } DecodeCtrl;

    typedef struct packed {
        InstAddr   pc;
        Data       instIMM;
        Data       dataA;                // rs1 value
        Data       dataB;                // rs2 value
        DecodeCtrl ctrl;
    } IdExItem;

    typedef struct packed {
        InstAddr     pc;
        Data         aluResult;
        Data         storeData;
        RegAddr      regWrAddr;
        logic        regWrEnable;
        RegWrDataSel regWrDataSel;
        logic        memWrEnable;
        logic        memRdEnable;
        DataAccess   memAccess;
        logic        memUnsigned;
    } ExMemItem;

    // All-zero encodings give ADD and cleared enables
    localparam DecodeCtrl bubbleCtrl  = '0;
    localparam IdExItem   bubbleIdEx  = '0;
    localparam ExMemItem  bubbleExMem = '0;

endpackage

`default_nettype wire

// ==== source/InstDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module InstDecoder (
    input  RvTypes::Inst       i_inst,       // Instruction word
    output RvTypes::DecodeCtrl o_ctrl,       // Decoded controls
    output RvTypes::Data       o_instIMM,    // Sign extended immediate
    output RvTypes::RegAddr    o_rs1Addr,
    output RvTypes::RegAddr    o_rs2Addr
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    RvTypes::RegAddr rd;
    RvTypes::Data    immI;
    RvTypes::Data    immS;
    RvTypes::Data    immU;

    assign opcode    = i_inst[6:0];
    assign funct3    = i_inst[14:12];
    assign rd        = i_inst[11:7];
    assign o_rs1Addr = i_inst[19:15];
    assign o_rs2Addr = i_inst[24:20];

    assign immI = {{20{i_inst[31]}}, i_inst[31:20]};
    assign immS = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign immU = {i_inst[31:12], 12'b0};

    // Bit 30 selects SUB only for register ops, SRA for both
    function automatic RvTypes::AluOp aluOpFromFunct(input logic [2:0] funct,
                                                     input logic       alt,
                                                     input logic       isReg);
        case (funct)
            3'b000:  return (alt && isReg) ? RvTypes::AluOp_SUB : RvTypes::AluOp_ADD;
            3'b001:  return RvTypes::AluOp_SLL;
            3'b010:  return RvTypes::AluOp_SLT;
            3'b011:  return RvTypes::AluOp_SLTU;
            3'b100:  return RvTypes::AluOp_XOR;
            3'b101:  return alt ? RvTypes::AluOp_SRA : RvTypes::AluOp_SRL;
            3'b110:  return RvTypes::AluOp_OR;
            default: return RvTypes::AluOp_AND;
        endcase
    endfunction

    always_comb
    begin
        o_ctrl    = RvTypes::bubbleCtrl;   // Unknown opcodes stay a bubble
        o_instIMM = '0;
        case (opcode)
            RvTypes::opcodeOp:
            begin
                o_ctrl.regWrAddr   = rd;
                o_ctrl.regWrEnable = 1'b1;
                o_ctrl.operandASel = RvTypes::OperandASel_REG;
                o_ctrl.operandBSel = RvTypes::OperandBSel_REG;
                o_ctrl.aluControl  = aluOpFromFunct(funct3, i_inst[30], 1'b1);
            end
            RvTypes::opcodeOpImm:
            begin
                o_ctrl.regWrAddr   = rd;
                o_ctrl.regWrEnable = 1'b1;
                o_ctrl.operandASel = RvTypes::OperandASel_REG;
                o_ctrl.operandBSel = RvTypes::OperandBSel_IMM;
                o_ctrl.aluControl  = aluOpFromFunct(funct3, i_inst[30], 1'b0);
                o_instIMM          = immI;
            end
            RvTypes::opcodeLui, RvTypes::opcodeAuipc:
            begin
                o_ctrl.regWrAddr   = rd;
                o_ctrl.regWrEnable = 1'b1;
                o_ctrl.operandASel = (opcode == RvTypes::opcodeLui) ?
                                     RvTypes::OperandASel_ZERO : RvTypes::OperandASel_PC;
                o_ctrl.operandBSel = RvTypes::OperandBSel_IMM;
                o_instIMM          = immU;
            end
            RvTypes::opcodeLoad:
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101})
                begin
                    o_ctrl.regWrAddr    = rd;
                    o_ctrl.regWrEnable  = 1'b1;
                    o_ctrl.regWrDataSel = RvTypes::RegWrDataSel_MEM;
                    o_ctrl.memRdEnable  = 1'b1;
                    o_ctrl.memAccess    = RvTypes::DataAccess'(funct3[1:0]);
                    o_ctrl.memUnsigned  = funct3[2];
                    o_ctrl.operandASel  = RvTypes::OperandASel_REG;
                    o_ctrl.operandBSel  = RvTypes::OperandBSel_IMM;
                    o_instIMM           = immI;   // Address offset
                end
            RvTypes::opcodeStore:
                if (funct3 inside {3'b000, 3'b001, 3'b010})
                begin
                    o_ctrl.memWrEnable = 1'b1;
                    o_ctrl.memAccess   = RvTypes::DataAccess'(funct3[1:0]);
                    o_ctrl.operandASel = RvTypes::OperandASel_REG;
                    o_ctrl.operandBSel = RvTypes::OperandBSel_IMM;
                    o_instIMM          = immS;
                end
            default:
                o_ctrl = RvTypes::bubbleCtrl;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/RegisterFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module RegisterFile (
    input  wire logic            i_clock,
    input  wire logic            i_reset,
    input  RvTypes::RegAddr      i_rs1Addr,
    input  RvTypes::RegAddr      i_rs2Addr,
    output RvTypes::Data         o_rs1Data,
    output RvTypes::Data         o_rs2Data,
    input  RvTypes::RegAddr      i_wrAddr,     // Write-back port
    input  RvTypes::Data         i_wrData,
    input  wire logic            i_wrEnable
);

    RvTypes::Data regs [32];
    logic         wrValid;                    // x0 writes dropped
    logic         bypass1;
    logic         bypass2;

    assign wrValid = i_wrEnable && (i_wrAddr != '0);
    assign bypass1 = wrValid && (i_wrAddr == i_rs1Addr);
    assign bypass2 = wrValid && (i_wrAddr == i_rs2Addr);

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wrValid)
            regs[i_wrAddr] <= i_wrData;
    end

    // Write-first, incoming data wins over stored value
    assign o_rs1Data = (i_rs1Addr == '0) ? '0 : bypass1 ? i_wrData : regs[i_rs1Addr];
    assign o_rs2Data = (i_rs2Addr == '0) ? '0 : bypass2 ? i_wrData : regs[i_rs2Addr];

endmodule

`default_nettype wire

// ==== source/PipelineIDEX.sv ====
`timescale 1ns/1ps
`default_nettype none

module PipelineIDEX (
    input  wire logic       i_clock,
    input  wire logic       i_reset,
    input  wire logic       i_stall,    // Holds content, wins over flush
    input  wire logic       i_flush,    // Loads a bubble
    input  RvTypes::IdExItem i_item,
    output RvTypes::IdExItem o_item
);

    always_ff @(posedge i_clock)
    begin
        case ({i_reset, i_stall, i_flush})
            3'b000:                         // Normal
                o_item <= i_item;
            3'b001:                         // Flush
                o_item <= RvTypes::bubbleIdEx;
            3'b010,
            3'b011:                         // Stall
                o_item <= o_item;
            default:                        // Reset in any combination
                o_item <= RvTypes::bubbleIdEx;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/ExecuteStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ExecuteStage (
    input  RvTypes::IdExItem  i_item,
    output RvTypes::ExMemItem o_result
);

    RvTypes::Data operandA;
    RvTypes::Data operandB;
    RvTypes::Data aluResult;
    logic [4:0]   shamt;

    always_comb
    begin
        case (i_item.ctrl.operandASel)
            RvTypes::OperandASel_PC:   operandA = i_item.pc;
            RvTypes::OperandASel_ZERO: operandA = '0;    // LUI
            default:                   operandA = i_item.dataA;
        endcase
    end

    assign operandB = (i_item.ctrl.operandBSel == RvTypes::OperandBSel_IMM) ?
                      i_item.instIMM : i_item.dataB;
    assign shamt    = operandB[4:0];

    always_comb
    begin
        case (i_item.ctrl.aluControl)
            RvTypes::AluOp_SUB:  aluResult = operandA - operandB;
            RvTypes::AluOp_SLL:  aluResult = operandA << shamt;
            RvTypes::AluOp_SLT:
                aluResult = {31'b0, $signed(operandA) < $signed(operandB)};
            RvTypes::AluOp_SLTU: aluResult = {31'b0, operandA < operandB};
            RvTypes::AluOp_XOR:  aluResult = operandA ^ operandB;
            RvTypes::AluOp_SRL:  aluResult = operandA >> shamt;
            RvTypes::AluOp_SRA:  aluResult = RvTypes::Data'($signed(operandA) >>> shamt);
            RvTypes::AluOp_OR:   aluResult = operandA | operandB;
            RvTypes::AluOp_AND:  aluResult = operandA & operandB;
            default:             aluResult = operandA + operandB;   // ADD, also addresses
        endcase
    end

    always_comb
    begin
        o_result.pc           = i_item.pc;
        o_result.aluResult    = aluResult;
        o_result.storeData    = i_item.dataB;       // rs2 for stores
        o_result.regWrAddr    = i_item.ctrl.regWrAddr;
        o_result.regWrEnable  = i_item.ctrl.regWrEnable;
        o_result.regWrDataSel = i_item.ctrl.regWrDataSel;
        o_result.memWrEnable  = i_item.ctrl.memWrEnable;
        o_result.memRdEnable  = i_item.ctrl.memRdEnable;
        o_result.memAccess    = i_item.ctrl.memAccess;
        o_result.memUnsigned  = i_item.ctrl.memUnsigned;
    end

endmodule

`default_nettype wire

// ==== source/PipelineEXMEM.sv ====
`timescale 1ns/1ps
`default_nettype none

module PipelineEXMEM (
    input  wire logic         i_clock,
    input  wire logic         i_reset,
    input  wire logic         i_stall,     // ID/EX held, so no new item
    input  RvTypes::ExMemItem i_item,
    output RvTypes::ExMemItem o_item
);

    // A stalled ID/EX would repeat its item, a bubble keeps it single
    always_ff @(posedge i_clock)
    begin
        if (i_reset || i_stall)
            o_item <= RvTypes::bubbleExMem;
        else
            o_item <= i_item;
    end

endmodule

`default_nettype wire

// ==== source/ExecuteCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module ExecuteCore (
    input  wire logic         i_clock,
    input  wire logic         i_reset,
    input  wire logic         i_stall,
    input  wire logic         i_flush,
    input  RvTypes::Inst      i_inst,       // Held by the environment while stalled
    input  RvTypes::InstAddr  i_pc,
    input  RvTypes::RegAddr   i_wbAddr,     // Write-back port
    input  RvTypes::Data      i_wbData,
    input  wire logic         i_wbEnable,
    output RvTypes::ExMemItem o_exMem
);

    RvTypes::DecodeCtrl decCtrl;
    RvTypes::Data       decImm;
    RvTypes::RegAddr    rs1Addr;
    RvTypes::RegAddr    rs2Addr;
    RvTypes::Data       rs1Data;
    RvTypes::Data       rs2Data;
    RvTypes::IdExItem   idExIn;
    RvTypes::IdExItem   idExOut;
    RvTypes::ExMemItem  exResult;

    InstDecoder decoder (
        .i_inst    (i_inst),
        .o_ctrl    (decCtrl),
        .o_instIMM (decImm),
        .o_rs1Addr (rs1Addr),
        .o_rs2Addr (rs2Addr)
    );

    RegisterFile regFile (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_rs1Addr  (rs1Addr),
        .i_rs2Addr  (rs2Addr),
        .o_rs1Data  (rs1Data),
        .o_rs2Data  (rs2Data),
        .i_wrAddr   (i_wbAddr),
        .i_wrData   (i_wbData),
        .i_wrEnable (i_wbEnable)
    );

    assign idExIn = '{pc: i_pc, instIMM: decImm, dataA: rs1Data, dataB: rs2Data, ctrl: decCtrl};

    PipelineIDEX idEx (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_stall (i_stall),
        .i_flush (i_flush),
        .i_item  (idExIn),
        .o_item  (idExOut)
    );

    ExecuteStage execute (
        .i_item   (idExOut),
        .o_result (exResult)
    );

    PipelineEXMEM exMem (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_stall (i_stall),
        .i_item  (exResult),
        .o_item  (o_exMem)
    );

endmodule

`default_nettype wire

// ==== verification/ExecuteCoreChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module ExecuteCoreChecker (
    input  wire logic         i_clock,
    input  wire logic         i_reset,
    input  wire logic         i_stall,
    input  wire logic         i_flush,
    input  RvTypes::Inst      i_inst,
    input  RvTypes::InstAddr  i_pc,
    input  RvTypes::RegAddr   i_wbAddr,
    input  RvTypes::Data      i_wbData,
    input  wire logic         i_wbEnable,
    input  RvTypes::ExMemItem i_exMem,      // DUT output under test
    output int                o_compareCount,
    output int                o_errorCount
);

    RvTypes::Data      modelRegs [32];
    RvTypes::Inst      idInst;              // Model ID/EX stage, zero word is a bubble
    RvTypes::InstAddr  idPc;
    RvTypes::Data      idA;
    RvTypes::Data      idB;
    RvTypes::ExMemItem expected;            // Model EX/MEM stage
    RvTypes::Data      nextA;
    RvTypes::Data      nextB;
    logic              armed = 1'b0;        // Set once a reset edge is seen

    initial
    begin
        o_compareCount = 0;
        o_errorCount   = 0;
    end

    // ALU rule from the ISA: bit 30 picks SUB on register ops and SRA on shifts
    function automatic RvTypes::Data aluCalc(input logic [2:0] f3, input logic alt,
                                             input logic isReg, input RvTypes::Data x,
                                             input RvTypes::Data y);
        case (f3)
            3'b000:  return (alt && isReg) ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011:  return (x < y) ? 32'd1 : 32'd0;
            3'b100:  return x ^ y;
            3'b101:  return alt ? RvTypes::Data'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic RvTypes::ExMemItem expectedResult(input RvTypes::Inst inst,
                                                         input RvTypes::InstAddr pc,
                                                         input RvTypes::Data a,
                                                         input RvTypes::Data b);
        RvTypes::ExMemItem res;
        logic [2:0]        f3;
        RvTypes::Data      immI;
        RvTypes::Data      immS;
        RvTypes::Data      immU;
        res  = '0;
        f3   = inst[14:12];
        immI = {{20{inst[31]}}, inst[31:20]};
        immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        immU = {inst[31:12], 12'b0};
        case (inst[6:0])
            RvTypes::opcodeOp, RvTypes::opcodeOpImm:
            begin
                res.regWrAddr   = inst[11:7];
                res.regWrEnable = 1'b1;
                res.aluResult   = (inst[6:0] == RvTypes::opcodeOp) ?
                                  aluCalc(f3, inst[30], 1'b1, a, b) :
                                  aluCalc(f3, inst[30], 1'b0, a, immI);
            end
            RvTypes::opcodeLui, RvTypes::opcodeAuipc:
            begin
                res.regWrAddr   = inst[11:7];
                res.regWrEnable = 1'b1;
                res.aluResult   = (inst[6:0] == RvTypes::opcodeLui) ? immU : pc + immU;
            end
            RvTypes::opcodeLoad:
                if (f3 != 3'b011 && f3 != 3'b110 && f3 != 3'b111)
                begin
                    res.regWrAddr    = inst[11:7];
                    res.regWrEnable  = 1'b1;
                    res.regWrDataSel = RvTypes::RegWrDataSel_MEM;
                    res.memRdEnable  = 1'b1;
                    res.memAccess    = RvTypes::DataAccess'(f3[1:0]);
                    res.memUnsigned  = f3[2];
                    res.aluResult    = a + immI;     // Load address
                end
            RvTypes::opcodeStore:
                if (f3[2] == 1'b0 && f3[1:0] != 2'b11)
                begin
                    res.memWrEnable = 1'b1;
                    res.memAccess   = RvTypes::DataAccess'(f3[1:0]);
                    res.aluResult   = a + immS;
                end
            default:
                res = '0;                            // Bubble
        endcase
        if (res.regWrEnable || res.memWrEnable || res.memRdEnable)
        begin
            res.pc        = pc;
            res.storeData = b;
        end
        return res;
    endfunction

    task automatic checkField(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (exp !== act)
        begin
            $display("error at %0t: exMem.%s expected %h actual %h", $time, name, exp, act);
            o_errorCount++;
        end
    endtask

    // Operand read with the write-first bypass of the port
    function automatic RvTypes::Data readModel(input RvTypes::RegAddr addr);
        if (addr == '0)
            return '0;
        if (i_wbEnable && i_wbAddr == addr)
            return i_wbData;
        return modelRegs[addr];
    endfunction

    always @(posedge i_clock)
    begin
        if (armed)
        begin
            checkField("regWrAddr", 32'(expected.regWrAddr), 32'(i_exMem.regWrAddr));
            checkField("regWrEnable", 32'(expected.regWrEnable), 32'(i_exMem.regWrEnable));
            checkField("regWrDataSel", 32'(expected.regWrDataSel), 32'(i_exMem.regWrDataSel));
            checkField("memWrEnable", 32'(expected.memWrEnable), 32'(i_exMem.memWrEnable));
            checkField("memRdEnable", 32'(expected.memRdEnable), 32'(i_exMem.memRdEnable));
            checkField("memAccess", 32'(expected.memAccess), 32'(i_exMem.memAccess));
            checkField("memUnsigned", 32'(expected.memUnsigned), 32'(i_exMem.memUnsigned));
            if (expected.regWrEnable || expected.memWrEnable || expected.memRdEnable)
            begin
                checkField("pc", expected.pc, i_exMem.pc);
                checkField("aluResult", expected.aluResult, i_exMem.aluResult);
                checkField("storeData", expected.storeData, i_exMem.storeData);
            end
            o_compareCount++;
        end
        nextA = readModel(i_inst[19:15]);
        nextB = readModel(i_inst[24:20]);
        if (i_reset)
        begin
            expected = '0;
            idInst   = '0;
            idPc     = '0;
            idA      = '0;
            idB      = '0;
            for (int i = 0; i < 32; i++)
                modelRegs[i] = '0;
            armed = 1'b1;
        end
        else
        begin
            expected = i_stall ? '0 : expectedResult(idInst, idPc, idA, idB);
            if (!i_stall)
            begin
                idInst = i_flush ? '0 : i_inst;
                idPc   = i_flush ? '0 : i_pc;
                idA    = nextA;
                idB    = nextB;
            end
            if (i_wbEnable && i_wbAddr != '0)
                modelRegs[i_wbAddr] = i_wbData;
        end
    end

endmodule

`default_nettype wire

// ==== verification/ExecuteCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ExecuteCoreTb;

    logic              clock = 1'b0;
    logic              reset;
    logic              stall;
    logic              flush;
    RvTypes::Inst      inst;
    RvTypes::InstAddr  pc;
    RvTypes::RegAddr   wbAddr;
    RvTypes::Data      wbData;
    logic              wbEnable;
    RvTypes::ExMemItem exMem;
    int                compareCount;
    int                errorCount;
    int                timeouts;
    int                seed;
    int                startCompares;
    int                startErrors;
    logic [31:0]       r1;
    logic [31:0]       r2;
    logic              nextStall;
    RvTypes::Inst      nextInst;

    always #4 clock = ~clock;                // 8 ns period

    ExecuteCore ExecuteCore_i (
        .i_clock    (clock),
        .i_reset    (reset),
        .i_stall    (stall),
        .i_flush    (flush),
        .i_inst     (inst),
        .i_pc       (pc),
        .i_wbAddr   (wbAddr),
        .i_wbData   (wbData),
        .i_wbEnable (wbEnable),
        .o_exMem    (exMem)
    );

    ExecuteCoreChecker monitor (
        .i_clock        (clock),
        .i_reset        (reset),
        .i_stall        (stall),
        .i_flush        (flush),
        .i_inst         (inst),
        .i_pc           (pc),
        .i_wbAddr       (wbAddr),
        .i_wbData       (wbData),
        .i_wbEnable     (wbEnable),
        .i_exMem        (exMem),
        .o_compareCount (compareCount),
        .o_errorCount   (errorCount)
    );

    function automatic RvTypes::Inst randomOpInst(input logic [31:0] r);
        logic [2:0] f3;
        logic       alt;
        f3  = r[2:0];
        alt = (f3 == 3'b000 || f3 == 3'b101) && r[3];
        return {1'b0, alt, 5'b0, r[8:4], r[13:9], f3, r[18:14], RvTypes::opcodeOp};
    endfunction

    function automatic RvTypes::Inst randomOpImmInst(input logic [31:0] r,
                                                     input logic [31:0] imm);
        logic [2:0]  f3;
        logic [11:0] field;
        f3    = r[2:0];
        field = imm[11:0];
        if (f3 == 3'b001)
            field[11:5] = 7'b0;
        if (f3 == 3'b101)
            field[11:5] = {1'b0, r[3], 5'b0};    // SRLI or SRAI
        return {field, r[13:9], f3, r[18:14], RvTypes::opcodeOpImm};
    endfunction

    // Upper immediates, loads and stores with any funct3, and random words
    function automatic RvTypes::Inst randomMemInst(input logic [31:0] r,
                                                   input logic [31:0] imm);
        case (r[2:0])
            3'd0:    return {imm[31:12], r[10:6], RvTypes::opcodeLui};
            3'd1:    return {imm[31:12], r[10:6], RvTypes::opcodeAuipc};
            3'd2,
            3'd3:    return {imm[11:0], r[15:11], r[5:3], r[10:6], RvTypes::opcodeLoad};
            3'd4,
            3'd5:    return {imm[11:5], r[20:16], r[15:11], r[5:3], imm[4:0],
                             RvTypes::opcodeStore};
            default: return imm;
        endcase
    endfunction

    task automatic driveCycle(input RvTypes::Inst i, input logic s, input logic f,
                              input RvTypes::RegAddr wa, input RvTypes::Data wd,
                              input logic we);
        @(posedge clock);
        inst     <= stall ? inst : i;        // Held until ID/EX takes it
        pc       <= stall ? pc : pc + 32'd4;
        stall    <= s;
        flush    <= f;
        wbAddr   <= wa;
        wbData   <= wd;
        wbEnable <= we;
    endtask

    task automatic startTest();
        @(negedge clock);
        startCompares = compareCount;
        startErrors   = errorCount;
    endtask

    // Drains the pipe, then waits for the compares of the test
    task automatic finishTest(input string name, input int cycles);
        int waited;
        waited = 0;
        driveCycle('0, 1'b0, 1'b0, '0, '0, 1'b0);
        driveCycle('0, 1'b0, 1'b0, '0, '0, 1'b0);
        @(negedge clock);
        while (compareCount < startCompares + cycles + 4 && waited < 50)
        begin
            @(negedge clock);
            waited++;
        end
        if (compareCount < startCompares + cycles + 4)
        begin
            $display("Timeout: checker did not finish its compares in test %s", name);
            timeouts++;
        end
        else
            $display("test %s: %0d compares, %0d errors", name,
                     compareCount - startCompares, errorCount - startErrors);
    endtask

    initial
    begin
        seed     = 32'hbc96_1510;
        timeouts = 0;
        reset    = 1'b1;
        stall    = 1'b0;
        flush    = 1'b0;
        inst     = '0;
        pc       = 32'h0000_1000;
        wbAddr   = '0;
        wbData   = '0;
        wbEnable = 1'b0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;

        startTest();
        driveCycle(32'h0050_0093, 1'b0, 1'b0, '0, '0, 1'b0);   // ADDI x1, x0, 5
        finishTest("after reset", 1);

        startTest();
        for (int i = 0; i < 32; i++)
        begin
            r1 = $random(seed);
            driveCycle('0, 1'b0, 1'b0, RvTypes::RegAddr'(i), r1, 1'b1);
        end
        finishTest("register init", 32);

        startTest();
        for (int i = 0; i < 200; i++)
        begin
            r1 = $random(seed);
            r2 = $random(seed);
            driveCycle(r1[31] ? randomOpInst(r1) : randomOpImmInst(r1, r2),
                       1'b0, 1'b0, '0, '0, 1'b0);
        end
        finishTest("alu ops", 200);

        startTest();
        for (int i = 0; i < 200; i++)
        begin
            r1 = $random(seed);
            r2 = $random(seed);
            driveCycle(randomMemInst(r1, r2), 1'b0, 1'b0, '0, '0, 1'b0);
        end
        finishTest("upper imm and memory", 200);

        startTest();
        for (int i = 0; i < 200; i++)
        begin
            r1        = $random(seed);
            r2        = $random(seed);
            nextStall = (r1[21:20] == 2'b00);
            driveCycle(randomOpInst(r2), nextStall, r1[23:22] == 2'b00, '0, '0, 1'b0);
        end
        finishTest("stall and flush", 200);

        startTest();
        for (int i = 0; i < 200; i++)
        begin
            r1       = $random(seed);
            r2       = $random(seed);
            nextInst = (i < 16) ? (randomOpInst(r1) & 32'hfff0_7fff) : randomOpInst(r1);
            // Same-cycle write to rs1 or rs2 exercises the bypass
            driveCycle(nextInst, 1'b0, 1'b0,
                       r2[0] ? ((r2[7] && i >= 16) ? nextInst[24:20] : nextInst[19:15])
                             : r2[5:1],
                       r2, (i < 16) || r2[6]);
        end
        finishTest("write-back port", 200);

        $display("compares %0d, errors %0d, timeouts %0d", compareCount, errorCount,
                 timeouts);
        if (errorCount == 0 && timeouts == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
source/RvTypes.sv
source/InstDecoder.sv
source/RegisterFile.sv
source/PipelineIDEX.sv
source/ExecuteStage.sv
source/PipelineEXMEM.sv
source/ExecuteCore.sv
verification/ExecuteCoreChecker.sv
verification/ExecuteCoreTb.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the ExecuteCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal -f project.f --top-module ExecuteCoreTb \
    -o ExecuteCoreTb > build.log 2>&1 \
    && ./obj_dir/ExecuteCoreTb > sim.log 2>&1 \
    || { cat build.log; cat sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat sim.log

grep -q "^Simulation PASSED$" sim.log && { echo "Result: pass"; exit 0; } \
    || { echo "Result: fail"; exit 1; }
